// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	// datapath widths
	localparam int xlen      = 32;
	localparam int reg_idx_w = 5;
	localparam int pc_w      = 12;

	// major opcodes kept in this slice
	localparam logic [6:0] op_rtype = 7'b0110011;
	localparam logic [6:0] op_itype = 7'b0010011;
	localparam logic [6:0] op_lui   = 7'b0110111;

	// funct3 codes of the integer ALU group
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// funct7, base form and the sub/sra form
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// alu operation, pass_b forwards operand b for lui
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b
	} alu_op_t;

endpackage

// ==== pipe_types_pkg.sv ====
package pipe_types_pkg;

	// payload between decode and execute
	// opb already holds the immediate when the instruction uses one
	typedef struct packed {
		logic [rv_isa_pkg::pc_w-1:0]      pc;
		logic [rv_isa_pkg::xlen-1:0]      opa;
		logic [rv_isa_pkg::xlen-1:0]      opb;
		logic [rv_isa_pkg::reg_idx_w-1:0] rd;
		rv_isa_pkg::alu_op_t              alu_op;
		logic                             is_comp;
		logic                             wr_en;
	} id_exe_t;

	// payload between execute and writeback
	typedef struct packed {
		logic [rv_isa_pkg::pc_w-1:0]      pc;
		logic [rv_isa_pkg::reg_idx_w-1:0] rd;
		logic [rv_isa_pkg::xlen-1:0]      result;
		logic                             wr_en;
	} exe_wb_t;

endpackage

// ==== rf_read_if.sv ====
interface rf_read_if;
	import rv_isa_pkg::*;

	// source register indices from decode
	logic [reg_idx_w-1:0] rs1_addr;
	logic [reg_idx_w-1:0] rs2_addr;

	// read data, combinational from the register array
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	modport decoder (
		output rs1_addr,
		output rs2_addr,
		input  rs1_data,
		input  rs2_data
	);

	modport reg_file (
		input  rs1_addr,
		input  rs2_addr,
		output rs1_data,
		output rs2_data
	);

endinterface

// ==== pipe_reg.sv ====
module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     nrst,

	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     full;
	payload_t data_q;

	// accept when empty or when the held entry leaves this cycle
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			full   <= 1'b0;
			data_q <= '0;
		end else begin
			if (in_valid && in_ready) begin
				full   <= 1'b1;
				data_q <= in_data;
			end else if (full && out_ready) begin
				// drained with nothing behind it
				full <= 1'b0;
			end
		end
	end

endmodule

// ==== reg_file.sv ====
module reg_file (
	input  logic                             clk,
	input  logic                             nrst,

	rf_read_if.reg_file                      rd_port,

	input  logic                             wr_en,
	input  logic [rv_isa_pkg::reg_idx_w-1:0] wr_addr,
	input  logic [rv_isa_pkg::xlen-1:0]      wr_data
);
	import rv_isa_pkg::*;

	localparam int n_regs = 1 << reg_idx_w;

	logic [xlen-1:0] regs [n_regs];

	// single write port, x0 never written
	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// asynchronous reads
	always_comb begin
		if (rd_port.rs1_addr == '0) begin
			rd_port.rs1_data = '0;
		end else begin
			rd_port.rs1_data = regs[rd_port.rs1_addr];
		end

		if (rd_port.rs2_addr == '0) begin
			rd_port.rs2_data = '0;
		end else begin
			rd_port.rs2_data = regs[rd_port.rs2_addr];
		end
	end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
	input  logic [31:0]                 inst,
	input  logic [rv_isa_pkg::pc_w-1:0] pc,
	input  logic                        in_valid,

	rf_read_if.decoder                  rf,

	input  pipe_types_pkg::exe_wb_t     exe_fwd,
	input  logic                        exe_fwd_valid,
	input  pipe_types_pkg::exe_wb_t     wb_fwd,
	input  logic                        wb_fwd_valid,

	output logic                        out_valid,
	output pipe_types_pkg::id_exe_t     out_data
);
	import rv_isa_pkg::*;
	import pipe_types_pkg::*;

	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [reg_idx_w-1:0] rs1;
	logic [reg_idx_w-1:0] rs2;
	logic [reg_idx_w-1:0] rd;
	logic [xlen-1:0]      imm_i;
	logic [xlen-1:0]      imm_u;
	logic [xlen-1:0]      rs1_val;
	logic [xlen-1:0]      rs2_val;
	logic                 supported;
	logic                 use_imm;
	logic                 is_lui;
	alu_op_t              alu_op;

	// funct3 to alu op, alt picks sub or sra
	function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			f3_add_sub: return alt ? alu_sub : alu_add;
			f3_sll:     return alu_sll;
			f3_slt:     return alu_slt;
			f3_sltu:    return alu_sltu;
			f3_xor:     return alu_xor;
			f3_srl_sra: return alt ? alu_sra : alu_srl;
			f3_or:      return alu_or;
			default:    return alu_and;
		endcase
	endfunction

	// youngest producer wins, then writeback, then the array
	function automatic logic [xlen-1:0] fwd_operand(
		input logic [reg_idx_w-1:0] idx,
		input logic [xlen-1:0]      rf_val,
		input exe_wb_t              exe,
		input logic                 exe_v,
		input exe_wb_t              wb,
		input logic                 wb_v
	);
		if (idx == '0)
			return '0;
		if (exe_v && exe.wr_en && (exe.rd == idx))
			return exe.result;
		if (wb_v && wb.wr_en && (wb.rd == idx))
			return wb.result;
		return rf_val;
	endfunction

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};

	assign rf.rs1_addr = rs1;
	assign rf.rs2_addr = rs2;

	assign rs1_val = fwd_operand(rs1, rf.rs1_data, exe_fwd, exe_fwd_valid,
		wb_fwd, wb_fwd_valid);
	assign rs2_val = fwd_operand(rs2, rf.rs2_data, exe_fwd, exe_fwd_valid,
		wb_fwd, wb_fwd_valid);

	always_comb begin
		supported = 1'b0;
		use_imm   = 1'b0;
		is_lui    = 1'b0;
		alu_op    = alu_add;
		case (opcode)
			op_rtype: begin
				// only add/sub and srl/sra take the alternate funct7
				supported = (funct7 == f7_base) ||
					((funct7 == f7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
				alu_op = alu_from_funct(funct3, funct7[5]);
			end
			op_itype: begin
				use_imm = 1'b1;
				if (funct3 == f3_sll)
					supported = (funct7 == f7_base);
				else if (funct3 == f3_srl_sra)
					supported = (funct7 == f7_base) || (funct7 == f7_alt);
				else
					supported = 1'b1;
				// upper immediate bits only mean sra for the shift form
				alu_op = alu_from_funct(funct3, (funct3 == f3_srl_sra) && funct7[5]);
			end
			op_lui: begin
				supported = 1'b1;
				use_imm   = 1'b1;
				is_lui    = 1'b1;
				alu_op    = alu_pass_b;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	assign out_valid = in_valid && supported;

	always_comb begin
		out_data.pc      = pc;
		out_data.opa     = rs1_val;
		out_data.opb     = use_imm ? (is_lui ? imm_u : imm_i) : rs2_val;
		out_data.rd      = rd;
		out_data.alu_op  = alu_op;
		out_data.is_comp = (alu_op == alu_slt) || (alu_op == alu_sltu);
		out_data.wr_en   = supported;
	end

endmodule

// ==== exec_stage.sv ====
module exec_stage (
	input  pipe_types_pkg::id_exe_t in_data,
	output pipe_types_pkg::exe_wb_t out_data
);
	import rv_isa_pkg::*;

	logic [xlen-1:0] opa;
	logic [xlen-1:0] opb;
	logic [4:0]      shamt;
	logic [xlen-1:0] alu_res;
	logic            less_than;

	assign opa   = in_data.opa;
	assign opb   = in_data.opb;
	assign shamt = opb[4:0];

	always_comb begin
		case (in_data.alu_op)
			alu_add:    alu_res = opa + opb;
			alu_sub:    alu_res = opa - opb;
			alu_and:    alu_res = opa & opb;
			alu_or:     alu_res = opa | opb;
			alu_xor:    alu_res = opa ^ opb;
			alu_sll:    alu_res = opa << shamt;
			alu_srl:    alu_res = opa >> shamt;
			alu_sra:    alu_res = $unsigned($signed(opa) >>> shamt);
			alu_pass_b: alu_res = opb;
			// comparisons go through the comparator below
			default:    alu_res = '0;
		endcase
	end

	// comparator, signed only for slt
	always_comb begin
		if (in_data.alu_op == alu_slt)
			less_than = $signed(opa) < $signed(opb);
		else
			less_than = opa < opb;
	end

	always_comb begin
		out_data.pc    = in_data.pc;
		out_data.rd    = in_data.rd;
		out_data.wr_en = in_data.wr_en;
		if (in_data.is_comp)
			out_data.result = {{(xlen-1){1'b0}}, less_than};
		else
			out_data.result = alu_res;
	end

endmodule

// ==== int_pipe_top.sv ====
module int_pipe_top (
	input  logic                             clk,
	input  logic                             nrst,

	input  logic                             in_valid,
	output logic                             in_ready,
	input  logic [31:0]                      in_inst,
	input  logic [rv_isa_pkg::pc_w-1:0]      in_pc,

	output logic                             res_valid,
	input  logic                             res_ready,
	output logic [rv_isa_pkg::reg_idx_w-1:0] res_rd,
	output logic [rv_isa_pkg::xlen-1:0]      res_data,
	output logic [rv_isa_pkg::pc_w-1:0]      res_pc
);
	import pipe_types_pkg::*;

	rf_read_if rf_rd ();

	logic    dec_valid;
	id_exe_t dec_data;
	logic    exe_valid;
	logic    exe_ready;
	id_exe_t exe_in;
	exe_wb_t exe_out;
	exe_wb_t wb_data;

	decode_stage decode_i (
		.inst          (in_inst),
		.pc            (in_pc),
		.in_valid      (in_valid),
		.rf            (rf_rd.decoder),
		.exe_fwd       (exe_out),
		.exe_fwd_valid (exe_valid),
		.wb_fwd        (wb_data),
		.wb_fwd_valid  (res_valid),
		.out_valid     (dec_valid),
		.out_data      (dec_data)
	);

	// unsupported words still handshake, they just never load
	pipe_reg #(.payload_t(id_exe_t)) id_exe_reg (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (dec_valid),
		.in_ready  (in_ready),
		.in_data   (dec_data),
		.out_valid (exe_valid),
		.out_ready (exe_ready),
		.out_data  (exe_in)
	);

	exec_stage exec_i (
		.in_data  (exe_in),
		.out_data (exe_out)
	);

	pipe_reg #(.payload_t(exe_wb_t)) exe_wb_reg (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (exe_valid),
		.in_ready  (exe_ready),
		.in_data   (exe_out),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (wb_data)
	);

	// writeback happens on the result handshake
	reg_file reg_file_i (
		.clk     (clk),
		.nrst    (nrst),
		.rd_port (rf_rd.reg_file),
		.wr_en   (res_valid && res_ready && wb_data.wr_en),
		.wr_addr (wb_data.rd),
		.wr_data (wb_data.result)
	);

	assign res_rd   = wb_data.rd;
	assign res_data = wb_data.result;
	assign res_pc   = wb_data.pc;

endmodule

// ==== tb_int_pipe.sv ====
module tb_int_pipe;

	localparam int n_dir   = 30;
	localparam int n_chain = 64;
	localparam int n_mix   = 300;
	localparam int n_bp    = 200;
	localparam int n_bad   = 100;
	localparam int n_rst   = 40;
	// four cycles per instruction covers drains and back-pressure
	localparam int max_cycles = 4 * (n_dir + n_chain + n_mix + n_bp + n_bad + n_rst) + 100;

	logic        clk;
	logic        nrst;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] in_inst;
	logic [11:0] in_pc;
	logic        res_valid;
	logic        res_ready;
	logic [4:0]  res_rd;
	logic [31:0] res_data;
	logic [11:0] res_pc;

	integer      seed;
	int          rr_mode;
	int          cyc;
	int          last_acc_cyc;
	int          last_res_cyc;
	int          n_checks;
	int          n_errs;
	logic [11:0] pc_next;
	logic [31:0] mregs [32];
	// expected {pc, rd, data}
	logic [48:0] exp_q [$];

	int_pipe_top int_pipe_top_i (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_inst   (in_inst),
		.in_pc     (in_pc),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_rd    (res_rd),
		.res_data  (res_data),
		.res_pc    (res_pc)
	);

	always #20 clk = ~clk;

	// 0 always ready, 1 random stalls, 2 held low
	always @(negedge clk) begin
		case (rr_mode)
			0: res_ready = 1'b1;
			1: res_ready = ({$random(seed)} % 4) != 0;
			default: res_ready = 1'b0;
		endcase
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errs++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// reference model, executes in order at the input handshake
	task automatic model_step(input logic [31:0] inst, input logic [11:0] pc);
		logic [6:0]  op;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic        ok;
		op = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		a  = mregs[inst[19:15]];
		b  = '0;
		r  = '0;
		ok = 1'b0;
		if (op == 7'h37) begin
			ok = 1'b1;
			r  = {inst[31:12], 12'h000};
		end else if (op == 7'h33 || op == 7'h13) begin
			if (op == 7'h33) begin
				b  = mregs[inst[24:20]];
				ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			end else begin
				b  = {{20{inst[31]}}, inst[31:20]};
				ok = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
			end
			case (f3)
				3'd0: r = (op == 7'h33 && f7[5]) ? a - b : a + b;
				3'd1: r = a << b[4:0];
				3'd2: r = {31'b0, $signed(a) < $signed(b)};
				3'd3: r = {31'b0, a < b};
				3'd4: r = a ^ b;
				3'd5: r = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
				3'd6: r = a | b;
				default: r = a & b;
			endcase
		end
		if (ok) begin
			exp_q.push_back({pc, inst[11:7], r});
			if (inst[11:7] != 5'd0) begin
				mregs[inst[11:7]] = r;
			end
		end
	endtask

	always @(posedge clk) begin
		logic [48:0] exp_e;
		cyc = cyc + 1;
		if (cyc > max_cycles) begin
			$display("timeout, results missing");
			$display("TEST FAIL");
			$finish;
		end else begin
			if (nrst && res_valid && res_ready) begin
				last_res_cyc = cyc;
				if (exp_q.size() == 0) begin
					$display("result with pc %h at %0t has no instruction behind it", res_pc, $time);
					n_errs++;
				end else begin
					exp_e = exp_q.pop_front();
					check_val("res_pc", res_pc, exp_e[48:37]);
					check_val("res_rd", res_rd, exp_e[36:32]);
					check_val("res_data", res_data, exp_e[31:0]);
				end
			end
			if (nrst && in_valid && in_ready) begin
				model_step(in_inst, in_pc);
				last_acc_cyc = cyc;
			end
		end
	end

	function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] itype_inst(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'h13};
	endfunction

	function automatic logic [31:0] lui_inst(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'h37};
	endfunction

	// bad_pct percent of words get an opcode outside the slice
	function automatic logic [31:0] rand_inst(input int bad_pct);
		int          kind;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [6:0]  op;
		logic [6:0]  f7;
		kind = {$random(seed)} % 100;
		f3   = $random(seed);
		rd   = $random(seed);
		rs1  = $random(seed);
		rs2  = $random(seed);
		imm  = $random(seed);
		if (kind < bad_pct) begin
			op = $random(seed);
			// the kept opcodes all have bit 6 clear
			if (op == 7'h33 || op == 7'h13 || op == 7'h37) begin
				op = op ^ 7'h40;
			end
			return {imm, rs1, f3, rd, op};
		end
		kind = {$random(seed)} % 10;
		if (kind < 1) begin
			return lui_inst({imm, rs2, f3}, rd);
		end else if (kind < 5) begin
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($random(seed) & 1)) ? 7'h20 : 7'h00;
			return rtype_inst(f7, rs2, rs1, f3, rd);
		end
		if (f3 == 3'd1) begin
			imm[11:5] = 7'h00;
		end else if (f3 == 3'd5) begin
			imm[11:5] = ($random(seed) & 1) ? 7'h20 : 7'h00;
		end
		return itype_inst(imm, rs1, f3, rd);
	endfunction

	task automatic send_inst(input logic [31:0] inst);
		@(negedge clk);
		in_valid = 1'b1;
		in_inst  = inst;
		in_pc    = pc_next;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
		pc_next = pc_next + 12'd4;
	endtask

	task automatic go_idle();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		go_idle();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// single instruction, then its latency from acceptance to result
	task automatic send_checked(input logic [31:0] inst);
		send_inst(inst);
		wait_drain();
		check_val("latency", last_res_cyc - last_acc_cyc, 32'd2);
	endtask

	task automatic do_reset();
		nrst     = 1'b0;
		in_valid = 1'b0;
		exp_q.delete();
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		repeat (5) @(negedge clk);
		nrst = 1'b1;
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("%-10s %s, %0d errors", name, (n_errs == err_start) ? "ok" : "failed",
			n_errs - err_start);
	endtask

	initial begin
		int          err_start;
		logic [31:0] inst;
		logic [4:0]  prev_rd;
		logic [4:0]  prev2_rd;
		logic [11:0] imm;
		seed      = 27;
		clk       = 1'b0;
		nrst      = 1'b0;
		in_valid  = 1'b0;
		in_inst   = '0;
		in_pc     = '0;
		res_ready = 1'b1;
		rr_mode   = 0;
		cyc       = 0;
		n_checks  = 0;
		n_errs    = 0;
		pc_next   = '0;
		do_reset();

		err_start = n_errs;
		send_checked(lui_inst(20'h80001, 5'd1));
		send_checked(itype_inst(12'hffd, 5'd1, 3'd0, 5'd1));
		send_checked(itype_inst(12'h007, 5'd0, 3'd0, 5'd2));
		send_checked(itype_inst(12'hff0, 5'd0, 3'd0, 5'd3));
		for (int f = 0; f < 8; f++) begin
			send_checked(rtype_inst(7'h00, 5'd2, 5'd1, 3'(f), 5'(8 + f)));
		end
		send_checked(rtype_inst(7'h20, 5'd2, 5'd1, 3'd0, 5'd16));
		send_checked(rtype_inst(7'h20, 5'd2, 5'd1, 3'd5, 5'd17));
		// negative against positive for both compares
		send_checked(rtype_inst(7'h00, 5'd2, 5'd3, 3'd2, 5'd18));
		send_checked(rtype_inst(7'h00, 5'd2, 5'd3, 3'd3, 5'd19));
		for (int f = 0; f < 8; f++) begin
			imm = (f == 1 || f == 5) ? 12'h005 : 12'h8f3;
			send_checked(itype_inst(imm, 5'd1, 3'(f), 5'(20 + f)));
		end
		send_checked(itype_inst(12'h405, 5'd1, 3'd5, 5'd28));
		report_test("directed", err_start);

		// each word reads the last rd from execute and the one before from writeback
		err_start = n_errs;
		prev_rd   = 5'd1;
		prev2_rd  = 5'd2;
		for (int i = 0; i < n_chain; i++) begin
			inst        = rand_inst(0);
			inst[11:7]  = 5'd1 + 5'({$random(seed)} % 31);
			inst[19:15] = prev_rd;
			if (inst[6:0] == 7'h33) begin
				inst[24:20] = prev2_rd;
			end
			send_inst(inst);
			prev2_rd = prev_rd;
			prev_rd  = inst[11:7];
		end
		wait_drain();
		report_test("chain", err_start);

		err_start = n_errs;
		for (int i = 0; i < n_mix; i++) begin
			send_inst(rand_inst(0));
			if ({$random(seed)} % 8 == 0) begin
				go_idle();
			end
		end
		wait_drain();
		report_test("mix", err_start);

		err_start = n_errs;
		rr_mode   = 1;
		for (int i = 0; i < n_bp; i++) begin
			send_inst(rand_inst(0));
		end
		wait_drain();
		report_test("backpress", err_start);

		err_start = n_errs;
		for (int i = 0; i < n_bad; i++) begin
			send_inst(rand_inst(25));
		end
		wait_drain();
		report_test("unsupp", err_start);

		// fill the pipe with held results, then reset underneath them
		err_start = n_errs;
		rr_mode   = 2;
		send_inst(itype_inst(12'h123, 5'd0, 3'd0, 5'd5));
		send_inst(itype_inst(12'h456, 5'd5, 3'd0, 5'd6));
		go_idle();
		repeat (3) @(negedge clk);
		// both stages full and the result port stalled
		check_val("res_valid", res_valid, 32'd1);
		check_val("in_ready", in_ready, 32'd0);
		do_reset();
		check_val("res_valid", res_valid, 32'd0);
		rr_mode = 0;
		for (int r = 0; r < 32; r++) begin
			send_inst(rtype_inst(7'h00, 5'd0, 5'(r), 3'd0, 5'(r)));
		end
		wait_drain();
		report_test("reset", err_start);

		if (exp_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_q.size());
			n_errs++;
		end
		$display("%0d checks, %0d errors", n_checks, n_errs);
		if (n_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== int_pipe_top.f ====
rv_isa_pkg.sv
pipe_types_pkg.sv
rf_read_if.sv
pipe_reg.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
int_pipe_top.sv
tb_int_pipe.sv
